// File: verilog.f
pf_pkg.sv
line_fetcher.sv
line_queue.sv
instr_aligner.sv
prefetch_buffer.sv
tb_imem_model.sv
tb_prefetch_buffer.sv

// File: tb_prefetch_buffer.sv
// table-driven testbench that branches into an LFSR-filled memory with random delays
// targets must be halfword aligned; the memory wraps every 1 KB
`timescale 1ns/1ps

module tb_prefetch_buffer
  import pf_pkg::*;
();

  localparam int MEM_LINES    = 64;
  localparam int TOTAL_HALVES = MEM_LINES * HALVES_PER_LINE;
  localparam int N_ROWS       = 8;

  typedef struct packed {
    addr_t      target;
    logic [7:0] count;     // instructions to accept after the branch
    logic       gated;     // ready_i follows the LFSR
    logic       hit_open;  // branch lands on an open request
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       branch_i;
  addr_t      addr_i;
  logic       ready_i;
  logic       valid_o;
  instr_t     rdata_o;
  addr_t      addr_o;
  logic       instr_req_o;
  addr_t      instr_addr_o;
  logic       instr_gnt_i;
  logic       instr_rvalid_i;
  line_t      instr_rdata_i;
  logic       busy_o;
  logic [1:0] gnt_dly;
  logic [1:0] rsp_dly;

  logic [15:0] lfsr_q = 16'd63043;
  half_t       halves [TOTAL_HALVES];  // expected memory image
  row_t        rows [N_ROWS];
  int          limit;
  int          crossings;    // 32-bit instructions taken from halfword 7
  logic        branched;
  addr_t       exp_addr_q;   // next address of the expected stream
  addr_t       line_exp_q;   // next line the fetcher may request
  logic        req_held_q;
  addr_t       held_addr_q;
  logic        in_flight_q;  // granted and still waiting for its line
  logic        hold_q;       // valid offer not taken last cycle
  addr_t       hold_addr_q;
  instr_t      hold_data_q;

  prefetch_buffer prefetch_buffer_i (.*);

  tb_imem_model #(.MEM_LINES(MEM_LINES)) imem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (instr_req_o),
    .addr_i      (instr_addr_o),
    .gnt_delay_i (gnt_dly),
    .rsp_delay_i (rsp_dly),
    .gnt_o       (instr_gnt_i),
    .rvalid_o    (instr_rvalid_i),
    .rdata_o     (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 16'hB400 : lfsr_q >> 1;
      v      = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic instr_t word_at(input addr_t a);
    int idx;
    idx = int'((a >> 1) % TOTAL_HALVES);
    return {halves[(idx + 1) % TOTAL_HALVES], halves[idx]};
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic addr_check(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // upper half is undefined for a 16-bit instruction
  task automatic instr_check(input string name, input instr_t got, input instr_t exp);
    logic bad;
    bad = (exp[1:0] == 2'b11) ? (got !== exp) : (got[15:0] !== exp[15:0]);
    if (bad) begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic load_table();
    rows[0] = {32'h0000_0040, 8'd24, 1'b0, 1'b0};
    rows[1] = {32'h0000_001E, 8'd12, 1'b1, 1'b0};  // line 1 ends in a 32-bit instruction
    rows[2] = {32'h0000_013A, 8'd20, 1'b0, 1'b1};
    rows[3] = {32'h0000_00AE, 8'd16, 1'b1, 1'b1};
    rows[4] = {32'h0000_03F0, 8'd20, 1'b0, 1'b0};  // runs over the memory wrap
    rows[5] = {32'h0000_02C6, 8'd30, 1'b1, 1'b1};
    rows[6] = {32'h0000_010E, 8'd10, 1'b0, 1'b1};
    rows[7] = {32'h0000_0200, 8'd40, 1'b1, 1'b0};
  endtask

  task automatic fill_memory();
    line_t l;
    for (int i = 0; i < TOTAL_HALVES; i++) begin
      halves[i] = rand_bits(16);
      // every third line ends in the first half of a 32-bit instruction
      if (i % HALVES_PER_LINE == HALVES_PER_LINE - 1 && (i / HALVES_PER_LINE) % 3 == 1) begin
        halves[i][1:0] = 2'b11;
      end
    end
    for (int n = 0; n < MEM_LINES; n++) begin
      for (int h = 0; h < HALVES_PER_LINE; h++) begin
        l[h * $bits(half_t) +: $bits(half_t)] = halves[n * HALVES_PER_LINE + h];
      end
      imem_i.mem[n] = l;
    end
  endtask

  // drive at the falling edge, check at the rising edge, return at the next falling edge
  task automatic run_cycle(input logic br, input addr_t tgt, input logic rdy, output logic took);
    instr_t exp_word;
    took     = 1'b0;
    branch_i = br;
    addr_i   = tgt;
    ready_i  = rdy;
    gnt_dly  = 2'(rand_bits(2));
    rsp_dly  = 2'(rand_bits(2));
    @(posedge clk);
    if (!branched) begin
      flag_check("instr_req_o", instr_req_o, 1'b0);
      flag_check("valid_o", valid_o, 1'b0);
      flag_check("busy_o", busy_o, 1'b0);
    end
    // memory port
    // fetcher is busy while a request waits for its grant or its line
    flag_check("busy_o", busy_o, req_held_q || in_flight_q);
    if (req_held_q) begin
      flag_check("instr_req_o", instr_req_o, 1'b1);
      addr_check("instr_addr_o", instr_addr_o, held_addr_q);
    end else if (instr_req_o) begin
      if (in_flight_q) begin
        $display("a new line request was raised before the previous response at %0t", $time);
        abort_run();
      end
      addr_check("instr_addr_o", instr_addr_o, line_exp_q);
      line_exp_q = line_exp_q + addr_t'(LINE_BYTES);
    end
    req_held_q  = instr_req_o && !instr_gnt_i;
    held_addr_q = instr_addr_o;
    if (instr_rvalid_i) begin
      in_flight_q = 1'b0;
    end
    if (instr_req_o && instr_gnt_i) begin
      in_flight_q = 1'b1;
    end
    // core port
    if (hold_q && !br) begin
      flag_check("valid_o", valid_o, 1'b1);
      addr_check("addr_o", addr_o, hold_addr_q);
      instr_check("rdata_o", rdata_o, hold_data_q);
    end
    if (br) begin
      flag_check("valid_o", valid_o, 1'b0);
      exp_addr_q = tgt;
      line_exp_q = tgt & ~addr_t'(LINE_BYTES - 1);
      branched   = 1'b1;
    end else if (valid_o && rdy) begin
      exp_word = word_at(exp_addr_q);
      addr_check("addr_o", addr_o, exp_addr_q);
      instr_check("rdata_o", rdata_o, exp_word);
      if (exp_word[1:0] == 2'b11 && exp_addr_q[3:1] == 3'(HALVES_PER_LINE - 1)) begin
        crossings++;
      end
      exp_addr_q = exp_addr_q + ((exp_word[1:0] == 2'b11) ? addr_t'(4) : addr_t'(2));
      took       = 1'b1;
    end
    hold_q      = valid_o && !rdy;
    hold_addr_q = addr_o;
    hold_data_q = rdata_o;
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int   total;
    int   got;
    logic rdy;
    logic took;
    rst_n       = 1'b0;
    branch_i    = 1'b0;
    addr_i      = '0;
    ready_i     = 1'b0;
    gnt_dly     = '0;
    rsp_dly     = '0;
    branched    = 1'b0;
    req_held_q  = 1'b0;
    in_flight_q = 1'b0;
    hold_q      = 1'b0;
    crossings   = 0;
    exp_addr_q  = '0;
    line_exp_q  = '0;
    load_table();
    fill_memory();
    total = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      total += rows[r].count;
    end
    limit = 40 * total + 10;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (5) run_cycle(1'b0, '0, 1'b0, took);  // port stays quiet until the first branch
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].hit_open) begin
        // detour first so that a fetch is open when the real branch comes
        run_cycle(1'b1, rows[r].target ^ addr_t'(32'h100), 1'b0, took);
        while (!busy_o) begin
          run_cycle(1'b0, '0, 1'b0, took);
        end
      end
      run_cycle(1'b1, rows[r].target, 1'b0, took);
      got = 0;
      while (got < rows[r].count) begin
        rdy = 1'b1;
        if (rows[r].gated) begin
          rdy = rand_bits(1) != 0;
        end
        run_cycle(1'b0, '0, rdy, took);
        if (took) begin
          got++;
        end
      end
    end
    if (crossings == 0) begin
      $display("no 32-bit instruction starting at halfword 7 was delivered");
      $display("TEST RESULT: FAIL");
      $fatal(1, "line crossing never exercised");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: tb_imem_model.sv
// testbench line memory, wraps every MEM_LINES lines
// delays are sampled each cycle, so a grant or response waits at most 3 cycles
`timescale 1ns/1ps

module tb_imem_model
  import pf_pkg::*;
#(
  parameter int MEM_LINES = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_i,
  input  addr_t      addr_i,
  input  logic [1:0] gnt_delay_i,
  input  logic [1:0] rsp_delay_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output line_t      rdata_o
);

  localparam int IDX_W = $clog2(MEM_LINES);
  localparam int OFS_W = $clog2(LINE_BYTES);

  line_t            mem [MEM_LINES];  // loaded by the testbench top
  logic [1:0]       gnt_wait_q;       // cycles the open request has waited
  logic             pend_q;           // granted, line not yet returned
  logic [1:0]       rsp_wait_q;
  logic [IDX_W-1:0] rsp_idx_q;

  assign gnt_o    = req_i && (gnt_wait_q >= gnt_delay_i);
  assign rvalid_o = pend_q && (rsp_wait_q >= rsp_delay_i);
  assign rdata_o  = mem[rsp_idx_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= '0;
      pend_q     <= 1'b0;
      rsp_wait_q <= '0;
      rsp_idx_q  <= '0;
    end else begin
      if (gnt_o || !req_i) begin
        gnt_wait_q <= '0;
      end else if (gnt_wait_q != 2'd3) begin
        gnt_wait_q <= gnt_wait_q + 1'b1;
      end
      if (gnt_o) begin
        pend_q     <= 1'b1;
        rsp_wait_q <= '0;  // response comes one cycle after the grant at the earliest
        rsp_idx_q  <= addr_i[OFS_W +: IDX_W];
      end else if (rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q && rsp_wait_q != 2'd3) begin
        rsp_wait_q <= rsp_wait_q + 1'b1;
      end
    end
  end

endmodule

// File: prefetch_buffer.sv
// instruction prefetch buffer on a 128-bit line port, one request in flight
// nothing is fetched until the first branch gives a start address
`timescale 1ns/1ps

module prefetch_buffer
  import pf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // core side
  input  logic   branch_i,
  input  addr_t  addr_i,
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,

  // memory side
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  line_t  instr_rdata_i,

  output logic   busy_o
);

  logic   line_valid;
  line_t  line_data;
  count_t line_count;
  line_t  head_line;
  line_t  next_line;
  logic   line_pop;

  line_fetcher line_fetcher_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .branch_addr_i  (addr_i),
    .line_count_i   (line_count),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .line_valid_o   (line_valid),
    .line_data_o    (line_data),
    .busy_o         (busy_o)
  );

  // a branch empties the queue
  line_queue line_queue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (line_valid),
    .push_line_i (line_data),
    .pop_i       (line_pop),
    .count_o     (line_count),
    .head_line_o (head_line),
    .next_line_o (next_line)
  );

  instr_aligner instr_aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .ready_i       (ready_i),
    .line_count_i  (line_count),
    .head_line_i   (head_line),
    .next_line_i   (next_line),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .pop_o         (line_pop)
  );

endmodule

// File: instr_aligner.sv
// extracts one instruction at the fetch address from the queued lines
// branch targets are assumed halfword aligned
`timescale 1ns/1ps

module instr_aligner
  import pf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  input  logic   ready_i,
  input  count_t line_count_i,
  input  line_t  head_line_i,
  input  line_t  next_line_i,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,
  output logic   pop_o
);

  localparam int IDX_W  = $clog2(HALVES_PER_LINE);
  localparam int HALF_W = $bits(half_t);

  addr_t            addr_q;
  logic [IDX_W-1:0] half_idx;
  logic [IDX_W-1:0] upper_idx;
  logic [IDX_W:0]   idx_sum;   // one extra bit catches the wrap
  logic             last_half;
  half_t            lower;
  half_t            upper;
  logic             is_comp;
  logic             avail;
  logic             accept;
  addr_t            addr_next;

  assign half_idx  = addr_q[IDX_W:1];
  assign upper_idx = half_idx + 1'b1;
  assign last_half = half_idx == IDX_W'(HALVES_PER_LINE - 1);

  ////////////////////////////////////////////////////////////////////////////
  // extraction
  ////////////////////////////////////////////////////////////////////////////

  assign lower = head_line_i[half_idx * HALF_W +: HALF_W];

  // at the line end the upper parcel is halfword 0 of the following line
  assign upper = last_half ? next_line_i[HALF_W-1:0]
                           : head_line_i[upper_idx * HALF_W +: HALF_W];

  assign is_comp = lower[1:0] != 2'b11;

  // a crossing 32-bit instruction needs both lines
  assign avail = (line_count_i != '0) &&
                 (is_comp || !last_half || line_count_i == count_t'(QUEUE_DEPTH));

  assign valid_o = avail && !branch_i;
  assign rdata_o = {upper, lower};
  assign accept  = valid_o && ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // address advance
  ////////////////////////////////////////////////////////////////////////////

  assign idx_sum   = {1'b0, half_idx} + (is_comp ? (IDX_W+1)'(1) : (IDX_W+1)'(2));
  assign addr_next = addr_q + (is_comp ? addr_t'(2) : addr_t'(4));
  assign pop_o     = accept && idx_sum[IDX_W];  // left the head line

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= branch_addr_i;
    end else if (accept) begin
      addr_q <= addr_next;
    end
  end

  assign addr_o = addr_q;

endmodule

// File: line_queue.sv
// two-line store kept in arrival order
// push without room is not checked; the fetcher guarantees it never happens
`timescale 1ns/1ps

module line_queue
  import pf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush_i,
  input  logic   push_i,
  input  line_t  push_line_i,
  input  logic   pop_i,
  output count_t count_o,
  output line_t  head_line_o,
  output line_t  next_line_o
);

  line_t  slots_q [QUEUE_DEPTH];
  count_t count_q;
  logic   pop_ok;
  count_t level;      // fill after this cycle's pop
  logic   push_slot;

  assign pop_ok    = pop_i && (count_q != '0);
  assign level     = count_q - count_t'(pop_ok);
  assign push_slot = level[0];  // 0 or 1 with two slots

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // the push is written after the shift, so it lands behind the remaining line
  always_ff @(posedge clk) begin
    if (pop_ok) begin
      slots_q[0] <= slots_q[1];
    end
    if (push_i) begin
      slots_q[push_slot] <= push_line_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (flush_i) begin
      count_q <= '0;              // flush beats a push in the same cycle
    end else begin
      count_q <= level + count_t'(push_i);
    end
  end

  assign count_o     = count_q;
  assign head_line_o = slots_q[0];
  assign next_line_o = slots_q[1];

endmodule

// File: line_fetcher.sv
// issues aligned line requests with at most one outstanding
// no request before the first branch; the queue must never be full on a push
`timescale 1ns/1ps

module line_fetcher
  import pf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  input  count_t line_count_i,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  line_t  instr_rdata_i,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  output logic   line_valid_o,
  output line_t  line_data_o,
  output logic   busy_o
);

  fetch_state_e state_q, state_d;
  logic         started_q;
  logic         stale_q, stale_d;
  addr_t        req_addr_q;    // held while the request waits for a grant
  addr_t        next_addr_q;   // next line to fetch
  logic         room;
  logic         grant_taken;

  // only one request is ever open, so a free slot now is still free at the response
  assign room        = line_count_i < count_t'(QUEUE_DEPTH);
  assign grant_taken = instr_req_o && instr_gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    stale_d      = stale_q;
    instr_req_o  = 1'b0;
    instr_addr_o = req_addr_q;
    line_valid_o = 1'b0;

    case (state_q)
      FETCH_IDLE: begin
        instr_addr_o = next_addr_q;
        if (started_q && !branch_i && room) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end
      FETCH_WAIT_GNT: begin
        instr_req_o = 1'b1;  // must stay up until granted, even across a branch
        if (branch_i) begin
          stale_d = 1'b1;
        end
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end
      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          line_valid_o = !stale_q;  // a branch in this cycle flushes the queue anyway
          stale_d      = 1'b0;
          state_d      = FETCH_IDLE;
        end else if (branch_i) begin
          stale_d = 1'b1;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FETCH_IDLE;
      started_q   <= 1'b0;
      stale_q     <= 1'b0;
      req_addr_q  <= '0;
      next_addr_q <= '0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
      if (branch_i) begin
        started_q <= 1'b1;
      end
      if (state_q == FETCH_IDLE && instr_req_o) begin
        req_addr_q <= next_addr_q;
      end
      // a grant for a stale request must not move the target line
      if (branch_i) begin
        next_addr_q <= branch_addr_i & ~addr_t'(LINE_BYTES - 1);
      end else if (grant_taken && !stale_q) begin
        next_addr_q <= next_addr_q + addr_t'(LINE_BYTES);
      end
    end
  end

  assign line_data_o = instr_rdata_i;
  assign busy_o      = state_q != FETCH_IDLE;

endmodule

// File: pf_pkg.sv
// shared widths and constants of the prefetch buffer
// line width is fixed at 128 bits; the halfword arithmetic depends on it

package pf_pkg;

  typedef logic [31:0]  addr_t;   // byte address
  typedef logic [31:0]  instr_t;  // instruction word, upper half unused when compressed
  typedef logic [15:0]  half_t;   // one instruction parcel
  typedef logic [127:0] line_t;   // memory line, halfword 0 in the low bits

  ////////////////////////////////////////////////////////////////////////////
  // line geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int LINE_BYTES      = 16;
  localparam int HALVES_PER_LINE = 8;

  // queue holds the current line and the one after it
  localparam int QUEUE_DEPTH = 2;

  typedef logic [1:0] count_t;  // lines held, 0 to QUEUE_DEPTH

  ////////////////////////////////////////////////////////////////////////////
  // memory-side controller states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FETCH_IDLE,         // no request open
    FETCH_WAIT_GNT,     // request raised, waiting for grant
    FETCH_WAIT_RVALID   // granted, waiting for the line
  } fetch_state_e;

endpackage
